// File: Makefile
VERILATOR := verilator
VFLAGS    := --timing
SIM_FLAGS := --binary -j 0
TOP       := frame_builder_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/frame_builder_tb.sv
`timescale 1ns/1ps
`include "frame_params.svh"

module frame_builder_tb;

    // --------------------
    // Run limits
    // --------------------
    localparam int NUM_TESTS      = 10;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 4 * (8 + `FRAME_MAX_DATA) + 100;

    localparam logic [1:0] BP_NONE   = 2'd0;  // FIFO always has room
    localparam logic [1:0] BP_RANDOM = 2'd1;  // tx_full from $random each cycle
    localparam logic [1:0] BP_LONG   = 2'd2;  // Long full stretches, short gaps

    // One table row, stimulus plus expected frame length
    typedef struct packed {
        frame_protocol_pkg::byte_t  status;
        frame_protocol_pkg::byte_t  cmd;
        logic [31:0]                addr;
        frame_protocol_pkg::count_t data_count;  // Before clamping
        logic [1:0]                 bp_mode;
        frame_protocol_pkg::count_t exp_len;     // Bytes on the wire
    } test_entry_t;

    logic                                  clk;
    logic                                  rst;
    frame_protocol_pkg::response_request_t request;
    frame_protocol_pkg::payload_t          payload;
    logic                                  build_response;
    logic                                  tx_full = 1'b0;
    frame_protocol_pkg::tx_byte_t          tx;
    logic                                  busy;
    logic                                  response_complete;

    test_entry_t               tests [NUM_TESTS];
    string                     names [NUM_TESTS];
    frame_protocol_pkg::byte_t exp_q[$];          // Reference frame
    frame_protocol_pkg::byte_t got_q[$];          // Every byte pushed, whole run
    integer     seed = 32'hb8a45328;
    int         bp_rnd;
    int         bp_phase = 0;
    logic [1:0] bp_mode = BP_NONE;
    int         value_errors = 0;
    int         full_writes = 0;                  // Pushes seen with tx_full high
    int         complete_total = 0;
    int         len_at_complete = 0;              // got_q size at the last pulse
    logic       busy_at_complete = 1'b0;
    int         cycle_count = 0;
    string      cur_name = "reset";

    frame_builder frame_builder_inst (
        .clk               (clk),
        .rst               (rst),
        .request           (request),
        .payload           (payload),
        .build_response    (build_response),
        .tx_full           (tx_full),
        .tx                (tx),
        .busy              (busy),
        .response_complete (response_complete)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // --------------------
    // Timeout and back-pressure
    // --------------------
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    always @(posedge clk) begin
        #1;
        case (bp_mode)
            BP_RANDOM: begin
                bp_rnd  = $random(seed);
                tx_full = bp_rnd[0];
            end
            BP_LONG: begin
                tx_full  = (bp_phase % 20) < 14;  // 14 full, 6 free
                bp_phase = bp_phase + 1;
            end
            default: begin
                tx_full  = 1'b0;
                bp_phase = 0;
            end
        endcase
    end

    // --------------------
    // FIFO port monitor
    // --------------------
    // Sampled mid-cycle, a write here lands on the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (tx.wr_en && tx_full) begin
                $display("Error: %s pushed a byte while tx_full was high", cur_name);
                full_writes = full_writes + 1;
            end
            if (tx.wr_en) begin
                got_q.push_back(tx.data);
            end
            if (response_complete) begin
                complete_total   = complete_total + 1;
                len_at_complete  = got_q.size();
                busy_at_complete = busy;  // Pulse must come before busy drops
            end
        end
    end

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_byte(input string name, input frame_protocol_pkg::byte_t exp,
                              input frame_protocol_pkg::byte_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %02h actual %02h", name, exp, act);
            value_errors = value_errors + 1;
        end
    endtask

    task automatic check_count(input string name, input frame_protocol_pkg::count_t exp,
                               input frame_protocol_pkg::count_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %0d actual %0d", name, exp, act);
            value_errors = value_errors + 1;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b actual %b", name, exp, act);
            value_errors = value_errors + 1;
        end
    endtask

    // --------------------
    // Reference model
    // --------------------
    // Bit-serial CRC-8, one input bit per shift
    function automatic frame_protocol_pkg::byte_t crc8_ref(input frame_protocol_pkg::byte_t c_in,
                                                           input frame_protocol_pkg::byte_t d);
        frame_protocol_pkg::byte_t c;
        logic                      fb;
        c = c_in;
        for (int b = 7; b >= 0; b--) begin
            fb = c[7] ^ d[b];
            c  = {c[6:0], 1'b0};
            if (fb) begin
                c = c ^ `CRC8_POLY;
            end
        end
        return c;
    endfunction

    task automatic build_expected(input test_entry_t e, input frame_protocol_pkg::payload_t p);
        frame_protocol_pkg::byte_t crc;
        logic                      ok;
        int                        n;
        exp_q.delete();
        ok = e.cmd[7] && ((e.status == `STATUS_OK_SPEC) || (e.status == `STATUS_OK_ALT1) ||
                          (e.status == `STATUS_OK_ALT2));
        n  = int'(e.data_count);
        if (n > `FRAME_MAX_DATA) begin
            n = `FRAME_MAX_DATA;  // Clamp
        end
        exp_q.push_back(`FRAME_SOF);
        exp_q.push_back(e.status);
        exp_q.push_back(e.cmd);
        if (ok) begin
            for (int i = 0; i < 4; i++) begin
                exp_q.push_back(e.addr[8*i +: 8]);  // LSB first
            end
            for (int i = 0; i < n; i++) begin
                exp_q.push_back(p[i]);
            end
        end
        crc = 8'h00;
        for (int i = 1; i < exp_q.size(); i++) begin
            crc = crc8_ref(crc, exp_q[i]);  // SOF not covered
        end
        exp_q.push_back(crc);
    endtask

    // --------------------
    // Stimulus
    // --------------------
    task automatic load_table();
        names[0] = "write_basic";
        tests[0] = '{8'h00, 8'h02, 32'h4000_1000, 7'd0, BP_NONE, 7'd4};
        names[1] = "write_random_bp";
        tests[1] = '{8'h00, 8'h03, 32'h4000_2000, 7'd5, BP_RANDOM, 7'd4};
        names[2] = "read_empty";
        tests[2] = '{8'h00, 8'h81, 32'h1234_5678, 7'd0, BP_NONE, 7'd8};
        names[3] = "read_one_alt1";
        tests[3] = '{8'h40, 8'h81, 32'hA5C3_0F96, 7'd1, BP_NONE, 7'd9};
        names[4] = "read_full_alt2";
        tests[4] = '{8'h80, 8'h82, 32'hDEAD_BEEF, 7'd64, BP_NONE, 7'd72};
        names[5] = "read_bad_status";
        tests[5] = '{8'h01, 8'h81, 32'h0000_0010, 7'd16, BP_NONE, 7'd4};
        names[6] = "read_clamped";
        tests[6] = '{8'h00, 8'h81, 32'h8000_0004, 7'd100, BP_NONE, 7'd72};
        names[7] = "read_random_bp";
        tests[7] = '{8'h00, 8'h83, 32'h0102_0304, 7'd20, BP_RANDOM, 7'd28};
        names[8] = "read_long_bp";
        tests[8] = '{8'h40, 8'h81, 32'hFFFF_FFFC, 7'd12, BP_LONG, 7'd20};
        names[9] = "read_full_random_bp";
        tests[9] = '{8'h80, 8'h81, 32'h5555_AAAA, 7'd64, BP_RANDOM, 7'd72};
    endtask

    task automatic run_test(input int t);
        test_entry_t e;
        int          base_len;
        int          base_done;
        e         = tests[t];
        base_len  = got_q.size();
        base_done = complete_total;
        @(posedge clk);
        #1;
        cur_name = names[t];
        for (int i = 0; i < `FRAME_MAX_DATA; i++) begin
            bp_rnd     = $random(seed);
            payload[i] = bp_rnd[7:0];
        end
        build_expected(e, payload);
        request.status     = e.status;
        request.cmd        = e.cmd;
        request.addr       = e.addr;
        request.data_count = e.data_count;
        build_response     = 1'b1;  // Rising edge, frame starts
        bp_mode            = e.bp_mode;
        @(posedge clk);
        #1 build_response = 1'b0;
        // Inputs change once captured, the frame must not follow them
        request = ~request;
        payload = ~payload;
        @(posedge clk);
        #1 build_response = 1'b1;   // Second edge while busy, must be ignored
        while (busy !== 1'b1) @(negedge clk);
        while (busy === 1'b1) @(negedge clk);
        bp_mode = BP_NONE;
        // Level still high, builder has to stay idle
        repeat (4) begin
            @(negedge clk);
            check_flag({cur_name, " idle after frame"}, 1'b0, busy);
        end
        @(posedge clk);
        #1 build_response = 1'b0;

        check_count({cur_name, " complete pulses"}, 7'd1,
                    frame_protocol_pkg::count_t'(complete_total - base_done));
        check_count({cur_name, " length at complete"}, e.exp_len,
                    frame_protocol_pkg::count_t'(len_at_complete - base_len));
        check_flag({cur_name, " busy at complete"}, 1'b1, busy_at_complete);
        check_count({cur_name, " frame length"}, e.exp_len,
                    frame_protocol_pkg::count_t'(got_q.size() - base_len));
        for (int i = 0; (i < exp_q.size()) && (base_len + i < got_q.size()); i++) begin
            check_byte($sformatf("%s byte %0d", cur_name, i), exp_q[i], got_q[base_len + i]);
        end
    endtask

    initial begin
        rst            = 1'b1;
        request        = '0;
        payload        = '0;
        build_response = 1'b0;
        load_table();
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_flag("reset busy", 1'b0, busy);
        check_flag("reset response_complete", 1'b0, response_complete);
        check_flag("reset wr_en", 1'b0, tx.wr_en);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Errors: %0d value, %0d write while full", value_errors, full_writes);
        if ((value_errors == 0) && (full_writes == 0)) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: hw/crc8_engine.sv
`timescale 1ns/1ps
`include "frame_params.svh"

module crc8_engine (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         crc_clear,  // Held while the builder idles
    input  logic                         crc_feed,   // Current field is covered
    input  frame_protocol_pkg::tx_byte_t tx,         // Same bundle the FIFO sees
    output frame_protocol_pkg::byte_t    crc
);

    frame_protocol_pkg::byte_t crc_next;

    // --------------------
    // Bytewise update
    // --------------------
    // Eight shift steps per byte, MSB first
    function automatic frame_protocol_pkg::byte_t crc8_byte(
        input frame_protocol_pkg::byte_t crc_in,
        input frame_protocol_pkg::byte_t data
    );
        frame_protocol_pkg::byte_t c;
        c = crc_in ^ data;
        for (int i = 0; i < 8; i++) begin
            if (c[7]) begin
                c = {c[6:0], 1'b0} ^ `CRC8_POLY;
            end else begin
                c = {c[6:0], 1'b0};
            end
        end
        return c;
    endfunction

    assign crc_next = crc8_byte(crc, tx.data);

    always_ff @(posedge clk) begin
        if (rst || crc_clear) begin
            crc <= '0;  // Init value 0x00
        end else if (tx.wr_en && crc_feed) begin
            crc <= crc_next;  // Only bytes that really reached the FIFO
        end
    end

endmodule

// File: hw/frame_builder.sv
`timescale 1ns/1ps

module frame_builder (
    input  logic                                 clk,
    input  logic                                 rst,
    input  frame_protocol_pkg::response_request_t request,
    input  frame_protocol_pkg::payload_t          payload,
    input  logic                                  build_response,  // Rising edge starts frame
    input  logic                                  tx_full,         // UART TX FIFO full
    output frame_protocol_pkg::tx_byte_t          tx,              // FIFO write port
    output logic                                  busy,
    output logic                                  response_complete
);

    // --------------------
    // Internal wiring
    // --------------------
    logic                           start;
    frame_builder_pkg::field_sel_t  sel;
    logic                           wr_en;
    logic                           step;
    logic                           crc_feed;
    logic                           crc_clear;
    logic                           has_body;
    logic                           addr_last;
    logic                           data_none;
    logic                           data_last;
    frame_builder_pkg::body_index_t index;
    frame_protocol_pkg::count_t     data_count;
    frame_protocol_pkg::byte_t      sel_byte;
    frame_protocol_pkg::byte_t      crc;

    // Strobe and byte leave together
    assign tx.data  = sel_byte;
    assign tx.wr_en = wr_en;

    frame_fsm frame_fsm_inst (
        .clk               (clk),
        .rst               (rst),
        .build_response    (build_response),
        .tx_full           (tx_full),
        .has_body          (has_body),
        .addr_last         (addr_last),
        .data_none         (data_none),
        .data_last         (data_last),
        .start             (start),
        .sel               (sel),
        .wr_en             (wr_en),
        .step              (step),
        .crc_feed          (crc_feed),
        .crc_clear         (crc_clear),
        .busy              (busy),
        .response_complete (response_complete)
    );

    frame_byte_counter frame_byte_counter_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .step       (step),
        .data_count (data_count),
        .index      (index),
        .addr_last  (addr_last),
        .data_none  (data_none),
        .data_last  (data_last)
    );

    response_store response_store_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .request    (request),
        .payload    (payload),
        .sel        (sel),
        .index      (index),
        .crc        (crc),
        .sel_byte   (sel_byte),
        .data_count (data_count),
        .has_body   (has_body)
    );

    // Watches the FIFO port directly
    crc8_engine crc8_engine_inst (
        .clk       (clk),
        .rst       (rst),
        .crc_clear (crc_clear),
        .crc_feed  (crc_feed),
        .tx        (tx),
        .crc       (crc)
    );

endmodule

// File: hw/frame_builder_pkg.sv
`include "frame_params.svh"

package frame_builder_pkg;

    // --------------------
    // Builder states
    // --------------------
    typedef enum logic [3:0] {
        IDLE,    // Waiting for build_response edge
        SOF,     // 0x5A
        STATUS,  // Status byte
        CMD,     // Command echo
        ADDR,    // Four address bytes, read success only
        DATA,    // Payload bytes
        CRC,     // Trailing CRC-8
        DONE,    // response_complete pulse
        GAP      // One idle cycle between frames
    } frame_state_t;

    // --------------------
    // Field select
    // --------------------
    // Which field the store puts on the byte output
    typedef enum logic [2:0] {
        SEL_SOF,
        SEL_STATUS,
        SEL_CMD,
        SEL_BODY,  // Address or payload, picked by body index
        SEL_CRC
    } field_sel_t;

    // Position after CMD
    // 0..3 are address bytes, 4 onward is payload (up to 67)
    typedef logic [`FRAME_COUNT_W-1:0] body_index_t;

endpackage

// File: hw/frame_byte_counter.sv
`timescale 1ns/1ps
`include "frame_params.svh"

module frame_byte_counter (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,       // New frame, back to position 0
    input  logic                           step,        // Address or payload byte written
    input  frame_protocol_pkg::count_t     data_count,  // Clamped payload length
    output frame_builder_pkg::body_index_t index,
    output logic                           addr_last,
    output logic                           data_none,
    output logic                           data_last
);

    frame_builder_pkg::body_index_t last_addr_pos;  // Position 3
    frame_builder_pkg::body_index_t last_data_pos;  // 3 + count, at most 67

    // --------------------
    // End positions
    // --------------------
    assign last_addr_pos = frame_builder_pkg::body_index_t'(`FRAME_ADDR_BYTES - 1);
    assign last_data_pos = last_addr_pos + frame_builder_pkg::body_index_t'(data_count);

    assign addr_last = (index == last_addr_pos);
    assign data_last = (index == last_data_pos);  // Only looked at in DATA
    assign data_none = (data_count == '0);

    // --------------------
    // Position register
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            index <= '0;
        end else if (start) begin
            index <= '0;
        end else if (step) begin
            index <= index + 1'b1;  // Holds under back-pressure since step drops
        end
    end

endmodule

// File: hw/frame_fsm.sv
`timescale 1ns/1ps

module frame_fsm (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          build_response,  // Level, rising edge starts a frame
    input  logic                          tx_full,         // FIFO back-pressure
    input  logic                          has_body,        // Read success, send addr + data
    input  logic                          addr_last,       // On last address byte
    input  logic                          data_none,       // Zero payload bytes
    input  logic                          data_last,       // On last payload byte
    output logic                          start,           // Capture pulse
    output frame_builder_pkg::field_sel_t sel,
    output logic                          wr_en,
    output logic                          step,            // Advance body position
    output logic                          crc_feed,        // Byte counts toward CRC
    output logic                          crc_clear,
    output logic                          busy,
    output logic                          response_complete
);

    frame_builder_pkg::frame_state_t state;
    frame_builder_pkg::frame_state_t state_next;

    logic build_prev;   // Last cycle's build_response
    logic build_edge;
    logic field_state;  // State that writes a byte

    // --------------------
    // Edge detect
    // --------------------
    assign build_edge = build_response && !build_prev;
    assign start      = (state == frame_builder_pkg::IDLE) && build_edge;  // Ignored when busy

    // --------------------
    // Output decode
    // --------------------
    assign field_state = (state == frame_builder_pkg::SOF)    ||
                         (state == frame_builder_pkg::STATUS) ||
                         (state == frame_builder_pkg::CMD)    ||
                         (state == frame_builder_pkg::ADDR)   ||
                         (state == frame_builder_pkg::DATA)   ||
                         (state == frame_builder_pkg::CRC);

    assign wr_en    = field_state && !tx_full;  // Never push into a full FIFO
    assign crc_feed = (state == frame_builder_pkg::STATUS) ||
                      (state == frame_builder_pkg::CMD)    ||
                      (state == frame_builder_pkg::ADDR)   ||
                      (state == frame_builder_pkg::DATA);  // SOF and CRC excluded
    assign step     = wr_en && ((state == frame_builder_pkg::ADDR) ||
                                (state == frame_builder_pkg::DATA));

    assign crc_clear         = (state == frame_builder_pkg::IDLE);
    assign busy              = (state != frame_builder_pkg::IDLE);
    assign response_complete = (state == frame_builder_pkg::DONE);  // Cycle after CRC write

    always_comb begin
        case (state)
            frame_builder_pkg::STATUS: sel = frame_builder_pkg::SEL_STATUS;
            frame_builder_pkg::CMD:    sel = frame_builder_pkg::SEL_CMD;
            frame_builder_pkg::ADDR,
            frame_builder_pkg::DATA:   sel = frame_builder_pkg::SEL_BODY;
            frame_builder_pkg::CRC:    sel = frame_builder_pkg::SEL_CRC;
            default:                   sel = frame_builder_pkg::SEL_SOF;
        endcase
    end

    // --------------------
    // Next state
    // --------------------
    // Field states only move on a write, so back-pressure holds the frame in place
    always_comb begin
        state_next = state;
        case (state)
            frame_builder_pkg::IDLE:
                if (build_edge) state_next = frame_builder_pkg::SOF;
            frame_builder_pkg::SOF:
                if (wr_en) state_next = frame_builder_pkg::STATUS;
            frame_builder_pkg::STATUS:
                if (wr_en) state_next = frame_builder_pkg::CMD;
            frame_builder_pkg::CMD:
                if (wr_en) begin
                    // Writes and failed reads skip straight to CRC
                    state_next = has_body ? frame_builder_pkg::ADDR : frame_builder_pkg::CRC;
                end
            frame_builder_pkg::ADDR:
                if (wr_en && addr_last) begin
                    state_next = data_none ? frame_builder_pkg::CRC : frame_builder_pkg::DATA;
                end
            frame_builder_pkg::DATA:
                if (wr_en && data_last) state_next = frame_builder_pkg::CRC;
            frame_builder_pkg::CRC:
                if (wr_en) state_next = frame_builder_pkg::DONE;
            frame_builder_pkg::DONE:
                state_next = frame_builder_pkg::GAP;
            default:
                state_next = frame_builder_pkg::IDLE;  // GAP, plus any stray code
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= frame_builder_pkg::IDLE;
            build_prev <= 1'b0;
        end else begin
            state      <= state_next;
            build_prev <= build_response;
        end
    end

endmodule

// File: hw/frame_params.svh
`ifndef FRAME_PARAMS_SVH
`define FRAME_PARAMS_SVH

// --------------------
// Frame layout
// --------------------
`define FRAME_SOF        8'h5A  // Device-to-host start of frame
`define FRAME_MAX_DATA   64     // Payload limit per read response
`define FRAME_COUNT_W    7      // Holds 0..64, also wide enough for body positions
`define FRAME_ADDR_BYTES 4      // Address echo, LSB first

// --------------------
// CRC-8
// --------------------
// x^8 + x^2 + x + 1, init 0, MSB first, no reflection or final XOR
`define CRC8_POLY        8'h07

// --------------------
// Read success codes
// --------------------
`define STATUS_OK_SPEC   8'h00  // Spec value
`define STATUS_OK_ALT1   8'h40  // Also accepted by host
`define STATUS_OK_ALT2   8'h80  // Older success code, still accepted

`endif

// File: hw/frame_protocol_pkg.sv
`include "frame_params.svh"

package frame_protocol_pkg;

    // --------------------
    // Basic fields
    // --------------------
    typedef logic [7:0] byte_t;                     // One byte on the wire
    typedef logic [`FRAME_COUNT_W-1:0] count_t;     // Payload byte count

    // Payload buffer, byte 0 sits in the low bits and goes out first
    typedef byte_t [`FRAME_MAX_DATA-1:0] payload_t;

    // --------------------
    // Response request
    // --------------------
    // Everything the bridge hands over for one response, except payload
    typedef struct packed {
        byte_t       status;      // STATUS field
        byte_t       cmd;         // Echoed command, bit 7 set for reads
        logic [31:0] addr;        // Echoed address, sent LSB first
        count_t      data_count;  // Requested payload length, may exceed limit
    } response_request_t;

    // --------------------
    // FIFO write
    // --------------------
    // Byte plus strobe toward the UART TX FIFO
    // The CRC engine watches the same bundle
    typedef struct packed {
        byte_t data;   // Byte to push
        logic  wr_en;  // Push strobe, only when FIFO has room
    } tx_byte_t;

endpackage

// File: hw/response_store.sv
`timescale 1ns/1ps
`include "frame_params.svh"

module response_store (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 start,     // Capture request and payload
    input  frame_protocol_pkg::response_request_t request,
    input  frame_protocol_pkg::payload_t          payload,
    input  frame_builder_pkg::field_sel_t         sel,
    input  frame_builder_pkg::body_index_t        index,
    input  frame_protocol_pkg::byte_t             crc,
    output frame_protocol_pkg::byte_t             sel_byte,  // Byte for the FIFO
    output frame_protocol_pkg::count_t            data_count,
    output logic                                  has_body
);

    frame_protocol_pkg::response_request_t req_q;      // Captured request, count clamped
    frame_protocol_pkg::payload_t          payload_q;  // Captured payload
    frame_protocol_pkg::count_t            count_clamped;
    frame_builder_pkg::body_index_t        data_pos;   // Payload byte number
    logic                                  status_ok;

    // --------------------
    // Capture
    // --------------------
    assign count_clamped = (request.data_count > `FRAME_COUNT_W'(`FRAME_MAX_DATA)) ?
                           `FRAME_COUNT_W'(`FRAME_MAX_DATA) : request.data_count;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= '0;  // No stale read decode after reset
        end else if (start) begin
            req_q            <= request;
            req_q.data_count <= count_clamped;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            payload_q <= payload;
        end
    end

    assign data_count = req_q.data_count;

    // --------------------
    // Read success decode
    // --------------------
    assign status_ok = (req_q.status == `STATUS_OK_SPEC) ||
                       (req_q.status == `STATUS_OK_ALT1) ||
                       (req_q.status == `STATUS_OK_ALT2);
    assign has_body  = req_q.cmd[7] && status_ok;  // Read with a success code

    // --------------------
    // Byte select
    // --------------------
    assign data_pos = index - frame_builder_pkg::body_index_t'(`FRAME_ADDR_BYTES);

    always_comb begin
        case (sel)
            frame_builder_pkg::SEL_STATUS: sel_byte = req_q.status;
            frame_builder_pkg::SEL_CMD:    sel_byte = req_q.cmd;
            frame_builder_pkg::SEL_BODY: begin
                if (index < frame_builder_pkg::body_index_t'(`FRAME_ADDR_BYTES)) begin
                    sel_byte = req_q.addr[{index[1:0], 3'b000} +: 8];  // LSB first
                end else begin
                    sel_byte = payload_q[data_pos[5:0]];  // Byte 0 first
                end
            end
            frame_builder_pkg::SEL_CRC:    sel_byte = crc;
            default:                       sel_byte = `FRAME_SOF;
        endcase
    end

endmodule

// File: list.f
+incdir+hw
hw/frame_protocol_pkg.sv
hw/frame_builder_pkg.sv
hw/frame_fsm.sv
hw/frame_byte_counter.sv
hw/response_store.sv
hw/crc8_engine.sv
hw/frame_builder.sv
dv/frame_builder_tb.sv
